//--- logic/dcore_pkg.sv
`default_nettype none

package dcore_pkg;

    // adc slice geometry
    localparam int Nadc = 8;
    localparam int Nti = 4;

    // averaging exponent and its upper bound
    localparam int Navg_w = 4;
    localparam int Navg_max = 10;

    // averaging strobe divider setting
    localparam int Ndiv_w = 4;

    // prbs order and counter width
    localparam int Nprbs = 7;
    localparam int Ncnt = 32;

    typedef logic [Nadc-1:0] adc_mag_t;

    // unfolded code carries one extra bit for the sign
    typedef logic signed [Nadc:0] adc_code_t;

    // room for 2^Navg_max samples of adc_code_t
    typedef logic signed [Nadc+Navg_max:0] avg_sum_t;
    typedef logic [Navg_max:0] avg_cnt_t;

    typedef logic [Navg_w-1:0] navg_t;
    typedef logic [Ndiv_w-1:0] ndiv_t;
    typedef logic [Nti-1:0] rx_word_t;
    typedef logic [Ncnt-1:0] bit_cnt_t;

    typedef enum logic [1:0] {
        CHK_RESET,
        CHK_ALIGN,
        CHK_RUN,
        CHK_FREEZE
    } chk_mode_t;

endpackage

`default_nettype wire

//--- logic/dcore_cfg_intf.sv
`timescale 1ns/10ps
`default_nettype none

interface dcore_cfg_intf import dcore_pkg::*; ();

    // offset calibration controls
    logic en_pfd_cal;
    logic en_ext_offset;
    adc_code_t ext_offset [Nti];
    navg_t navg;

    // decision threshold and checker control
    adc_code_t thresh;
    chk_mode_t checker_mode;

    // per-slice unfolding and pfd offset calibration
    modport unfold (
        input en_pfd_cal,
        input en_ext_offset,
        input navg
    );

    // decision slicer and prbs checker
    modport chk (
        input checker_mode,
        input thresh
    );

endinterface

`default_nettype wire

//--- logic/avg_strobe_div.sv
`timescale 1ns/10ps
`default_nettype none

module avg_strobe_div import dcore_pkg::*; (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire ndiv_t ndiv_i,
    output logic avg_stb_o
);

    ndiv_t div_cnt;

    // down-counter, strobe fires on the zero count
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            div_cnt <= '0;
            avg_stb_o <= 1'b0;
        end else if (div_cnt == '0) begin
            div_cnt <= ndiv_i;
            avg_stb_o <= 1'b1;
        end else begin
            div_cnt <= div_cnt - ndiv_t'(1);
            avg_stb_o <= 1'b0;
        end
    end

    // strobe is single-cycle unless the divider is set to 0
    stb_single_cycle: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (avg_stb_o && (ndiv_i != '0) && $stable(ndiv_i)) |=> !avg_stb_o
    );

endmodule

`default_nettype wire

//--- logic/adc_unfolding.sv
`timescale 1ns/10ps
`default_nettype none

module adc_unfolding import dcore_pkg::*; (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire logic avg_stb_i,
    input wire adc_mag_t din_i,
    input wire logic sign_i,
    input wire adc_code_t ext_offset_i,
    dcore_cfg_intf.unfold cfg_i,
    output adc_code_t dout_o,
    output adc_code_t pfd_offset_o
);

    adc_code_t mag_ext;
    adc_code_t unfolded;
    adc_code_t offset_sel;

    avg_sum_t avg_sum;
    avg_sum_t sum_next;
    avg_cnt_t avg_cnt;
    avg_cnt_t avg_last;

    // sign 1 means a positive sample
    assign mag_ext = adc_code_t'({1'b0, din_i});
    assign unfolded = sign_i ? mag_ext : -mag_ext;

    assign offset_sel = cfg_i.en_ext_offset ? ext_offset_i : pfd_offset_o;

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            dout_o <= '0;
        end else begin
            dout_o <= unfolded - offset_sel;
        end
    end

    // running sum including the current sample
    assign sum_next = avg_sum + avg_sum_t'(unfolded);

    // index of the last strobe in a window of 2^navg
    assign avg_last = (avg_cnt_t'(1) << cfg_i.navg) - avg_cnt_t'(1);

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            avg_sum <= '0;
            avg_cnt <= '0;
            pfd_offset_o <= '0;
        end else if (!cfg_i.en_pfd_cal) begin
            // idle, offset keeps the last calibrated value
            avg_sum <= '0;
            avg_cnt <= '0;
        end else if (avg_stb_i) begin
            if (avg_cnt == avg_last) begin
                // window complete, mean becomes the new offset
                pfd_offset_o <= adc_code_t'(sum_next >>> cfg_i.navg);
                avg_sum <= '0;
                avg_cnt <= '0;
            end else begin
                avg_sum <= sum_next;
                avg_cnt <= avg_cnt + avg_cnt_t'(1);
            end
        end
    end

    // accumulator is only sized for windows up to 2^Navg_max
    navg_in_range: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        cfg_i.en_pfd_cal |-> (cfg_i.navg <= Navg_max)
    );

endmodule

`default_nettype wire

//--- logic/slice_comparator.sv
`timescale 1ns/10ps
`default_nettype none

module slice_comparator import dcore_pkg::*; (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire adc_code_t codes_i [Nti],
    dcore_cfg_intf.chk cfg_i,
    output rx_word_t bits_o
);

    rx_word_t decision;

    // signed compare of every slice against the shared threshold
    always_comb begin
        for (int k = 0; k < Nti; k++) begin
            decision[k] = (codes_i[k] > cfg_i.thresh);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= decision;
        end
    end

endmodule

`default_nettype wire

//--- logic/prbs_checker.sv
`timescale 1ns/10ps
`default_nettype none

module prbs_checker import dcore_pkg::*; (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire rx_word_t rx_bits_i,
    dcore_cfg_intf.chk cfg_i,
    output bit_cnt_t correct_bits_o,
    output bit_cnt_t total_bits_o
);

    localparam int Next = Nprbs + Nti;
    localparam int Nmatch_w = $clog2(Nti + 1);

    // history, bit 0 is the oldest received bit
    logic [Nprbs-1:0] hist;

    // history followed by the new word in arrival order
    logic [Next-1:0] ext;
    rx_word_t expected;
    logic [Nmatch_w-1:0] match_cnt;

    assign ext = {rx_bits_i, hist};

    // x^7 + x^6 + 1, each bit predicted from 6 and 7 bits earlier
    always_comb begin
        match_cnt = '0;
        for (int k = 0; k < Nti; k++) begin
            expected[k] = ext[k] ^ ext[k + 1];
            if (rx_bits_i[k] == expected[k]) begin
                match_cnt = match_cnt + Nmatch_w'(1);
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            hist <= '0;
        end else if (cfg_i.checker_mode == CHK_RESET) begin
            hist <= '0;
        end else begin
            // newest Nprbs bits become the history
            hist <= ext[Next-1 -: Nprbs];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            correct_bits_o <= '0;
            total_bits_o <= '0;
        end else begin
            case (cfg_i.checker_mode)
                CHK_RESET: begin
                    correct_bits_o <= '0;
                    total_bits_o <= '0;
                end
                CHK_RUN: begin
                    correct_bits_o <= correct_bits_o + bit_cnt_t'(match_cnt);
                    total_bits_o <= total_bits_o + bit_cnt_t'(Nti);
                end
                // align and freeze hold the counts
                default: begin
                    correct_bits_o <= correct_bits_o;
                    total_bits_o <= total_bits_o;
                end
            endcase
        end
    end

    // matches can never outnumber checked bits
    correct_le_total: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        correct_bits_o <= total_bits_o
    );

endmodule

`default_nettype wire

//--- logic/rx_dcore_top.sv
`timescale 1ns/10ps
`default_nettype none

module rx_dcore_top import dcore_pkg::*; (
    input wire logic clk_adc,
    input wire logic reset_i,
    input wire adc_mag_t adcout_i [Nti],
    input wire logic [Nti-1:0] adcout_sign_i,
    input wire logic en_pfd_cal_i,
    input wire logic en_ext_offset_i,
    input wire adc_code_t ext_offset_i [Nti],
    input wire navg_t navg_i,
    input wire ndiv_t ndiv_avg_i,
    input wire adc_code_t thresh_i,
    input wire chk_mode_t checker_mode_i,
    output adc_code_t dout_o [Nti],
    output adc_code_t pfd_offset_o [Nti],
    output rx_word_t rx_bits_o,
    output bit_cnt_t correct_bits_o,
    output bit_cnt_t total_bits_o
);

    // configuration bundle
    dcore_cfg_intf cfg_intf_i ();

    logic avg_stb;

    assign cfg_intf_i.en_pfd_cal = en_pfd_cal_i;
    assign cfg_intf_i.en_ext_offset = en_ext_offset_i;
    assign cfg_intf_i.ext_offset = ext_offset_i;
    assign cfg_intf_i.navg = navg_i;
    assign cfg_intf_i.thresh = thresh_i;
    assign cfg_intf_i.checker_mode = checker_mode_i;

    // averaging strobe shared by all slices
    avg_strobe_div avg_div_i (
        .clk_adc(clk_adc),
        .reset_i(reset_i),
        .ndiv_i(ndiv_avg_i),
        .avg_stb_o(avg_stb)
    );

    for (genvar k = 0; k < Nti; k++) begin : g_slice
        adc_unfolding unfold_i (
            .clk_adc(clk_adc),
            .reset_i(reset_i),
            .avg_stb_i(avg_stb),
            .din_i(adcout_i[k]),
            .sign_i(adcout_sign_i[k]),
            .ext_offset_i(cfg_intf_i.ext_offset[k]),
            .cfg_i(cfg_intf_i.unfold),
            .dout_o(dout_o[k]),
            .pfd_offset_o(pfd_offset_o[k])
        );
    end

    // slice 0 is the earliest bit of each word
    slice_comparator slicer_i (
        .clk_adc(clk_adc),
        .reset_i(reset_i),
        .codes_i(dout_o),
        .cfg_i(cfg_intf_i.chk),
        .bits_o(rx_bits_o)
    );

    prbs_checker prbs_checker_i (
        .clk_adc(clk_adc),
        .reset_i(reset_i),
        .rx_bits_i(rx_bits_o),
        .cfg_i(cfg_intf_i.chk),
        .correct_bits_o(correct_bits_o),
        .total_bits_o(total_bits_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_rx_dcore.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rx_dcore import dcore_pkg::*; ();

    // stimulus kinds
    localparam int K_RAND = 0;
    localparam int K_CONST = 1;
    localparam int K_PRBS = 2;
    localparam int Nmargin = 20;

    typedef struct packed {
        int kind;
        logic en_ext;
        logic en_cal;
        navg_t navg;
        ndiv_t ndiv;
        adc_code_t thresh;
        chk_mode_t mode;
        int cycles;
        int flip_at;
        int exp_total;
        int exp_correct;
    } test_entry_t;

    logic clk_adc;
    logic reset;
    adc_mag_t adcout [Nti];
    logic [Nti-1:0] adcout_sign;
    logic en_pfd_cal;
    logic en_ext_offset;
    adc_code_t ext_offset [Nti];
    navg_t navg;
    ndiv_t ndiv_avg;
    adc_code_t thresh;
    chk_mode_t checker_mode;
    adc_code_t dout [Nti];
    adc_code_t pfd_offset [Nti];
    rx_word_t rx_bits;
    bit_cnt_t correct_bits;
    bit_cnt_t total_bits;

    test_entry_t tests [$];
    string test_names [$];
    int seed = 32'hed0f4e29;
    int errors;
    int tests_failed;
    int cycle_limit;

    // reference model state, one value per pipeline stage
    int m_dout [Nti];
    int exp_pfd [Nti];
    rx_word_t m_bits;
    logic [Nprbs-1:0] m_hist;
    int m_correct;
    int m_total;
    bit check_pfd;

    adc_mag_t const_mag [Nti];
    logic const_sign [Nti];
    // prbs7 source, bit 0 is the newest bit
    logic [Nprbs-1:0] gen_hist;

    initial begin
        clk_adc = 1'b0;
        forever begin
            #20 clk_adc = ~clk_adc;
        end
    end

    rx_dcore_top i_rx_dcore_top (
        .clk_adc(clk_adc),
        .reset_i(reset),
        .adcout_i(adcout),
        .adcout_sign_i(adcout_sign),
        .en_pfd_cal_i(en_pfd_cal),
        .en_ext_offset_i(en_ext_offset),
        .ext_offset_i(ext_offset),
        .navg_i(navg),
        .ndiv_avg_i(ndiv_avg),
        .thresh_i(thresh),
        .checker_mode_i(checker_mode),
        .dout_o(dout),
        .pfd_offset_o(pfd_offset),
        .rx_bits_o(rx_bits),
        .correct_bits_o(correct_bits),
        .total_bits_o(total_bits)
    );

    function automatic int unfold(logic sign, adc_mag_t mag);
        return sign ? int'(mag) : -int'(mag);
    endfunction

    function automatic logic prbs_next();
        logic b;
        b = gen_hist[Nprbs-2] ^ gen_hist[Nprbs-1];
        gen_hist = {gen_hist[Nprbs-2:0], b};
        return b;
    endfunction

    task automatic check_val(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic add_test(input string name, input int kind, input logic en_ext,
                            input logic en_cal, input int navg_v, input int ndiv_v,
                            input int thr, input chk_mode_t mode, input int cycles,
                            input int flip_at, input int exp_total, input int exp_correct);
        test_entry_t t;
        t.kind = kind;
        t.en_ext = en_ext;
        t.en_cal = en_cal;
        t.navg = navg_t'(navg_v);
        t.ndiv = ndiv_t'(ndiv_v);
        t.thresh = adc_code_t'(thr);
        t.mode = mode;
        t.cycles = cycles;
        t.flip_at = flip_at;
        t.exp_total = exp_total;
        t.exp_correct = exp_correct;
        tests.push_back(t);
        test_names.push_back(name);
    endtask

    task automatic drive_cycle(input test_entry_t t, input int cyc);
        logic b;
        for (int k = 0; k < Nti; k++) begin
            case (t.kind)
                K_RAND: begin
                    adcout[k] = adc_mag_t'($unsigned($random(seed)) % 240);
                    adcout_sign[k] = 1'($random(seed));
                end
                K_CONST: begin
                    adcout[k] = const_mag[k];
                    adcout_sign[k] = const_sign[k];
                end
                default: begin
                    b = prbs_next();
                    // single bit error on slice 1
                    if (cyc == t.flip_at && k == 1) begin
                        b = ~b;
                    end
                    adcout_sign[k] = b;
                    adcout[k] = b ? adc_mag_t'(1 + $unsigned($random(seed)) % 199)
                                  : adc_mag_t'($unsigned($random(seed)) % 200);
                end
            endcase
        end
    endtask

    task automatic step_and_check();
        @(posedge clk_adc);
        #2;
        // checker model walks the word bit by bit, slice 0 first
        if (checker_mode == CHK_RESET) begin
            m_hist = '0;
            m_correct = 0;
            m_total = 0;
        end else begin
            for (int k = 0; k < Nti; k++) begin
                if (checker_mode == CHK_RUN) begin
                    m_total++;
                    if (m_bits[k] == (m_hist[Nprbs-2] ^ m_hist[Nprbs-1])) begin
                        m_correct++;
                    end
                end
                m_hist = {m_hist[Nprbs-2:0], m_bits[k]};
            end
        end
        for (int k = 0; k < Nti; k++) begin
            m_bits[k] = (m_dout[k] > int'(thresh));
            m_dout[k] = unfold(adcout_sign[k], adcout[k])
                      - (en_ext_offset ? int'(ext_offset[k]) : exp_pfd[k]);
        end
        for (int k = 0; k < Nti; k++) begin
            check_val($sformatf("dout_o[%0d]", k), 32'(dout[k]), m_dout[k]);
            if (check_pfd) begin
                check_val($sformatf("pfd_offset_o[%0d]", k), 32'(pfd_offset[k]), exp_pfd[k]);
            end
        end
        check_val("rx_bits_o", 32'(rx_bits), 32'(m_bits));
        check_val("correct_bits_o", correct_bits, m_correct);
        check_val("total_bits_o", total_bits, m_total);
    endtask

    task automatic run_test(input int idx);
        test_entry_t t;
        int errs_before;
        t = tests[idx];
        errs_before = errors;
        // offset is in motion while calibrating
        check_pfd = !(t.kind == K_CONST && t.en_cal);
        en_pfd_cal = t.en_cal;
        en_ext_offset = t.en_ext;
        navg = t.navg;
        ndiv_avg = t.ndiv;
        thresh = t.thresh;
        checker_mode = t.mode;
        for (int k = 0; k < Nti; k++) begin
            ext_offset[k] = (t.kind == K_RAND) ? adc_code_t'($random(seed) % 16) : '0;
            if (t.kind == K_CONST && t.en_cal) begin
                const_mag[k] = adc_mag_t'($unsigned($random(seed)) % 200);
                const_sign[k] = 1'($random(seed));
            end
        end
        for (int c = 0; c < t.cycles; c++) begin
            drive_cycle(t, c);
            step_and_check();
        end
        if (t.kind == K_CONST && t.en_cal) begin
            // mean of a constant code is the code itself
            for (int k = 0; k < Nti; k++) begin
                exp_pfd[k] = unfold(const_sign[k], const_mag[k]);
                check_val($sformatf("pfd_offset_o[%0d]", k), 32'(pfd_offset[k]), exp_pfd[k]);
            end
        end
        if (t.exp_total >= 0) begin
            check_val("total_bits_o", total_bits, t.exp_total);
            check_val("correct_bits_o", correct_bits, t.exp_correct);
        end
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", idx + 1, test_names[idx],
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk_adc);
        while (cycles < cycle_limit) begin
            @(posedge clk_adc);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        errors = 0;
        tests_failed = 0;
        reset = 1'b1;
        for (int k = 0; k < Nti; k++) begin
            adcout[k] = '0;
            ext_offset[k] = '0;
            m_dout[k] = 0;
            exp_pfd[k] = 0;
        end
        adcout_sign = '0;
        en_pfd_cal = 1'b0;
        en_ext_offset = 1'b0;
        navg = '0;
        ndiv_avg = '0;
        thresh = '0;
        checker_mode = CHK_RESET;
        m_bits = '0;
        m_hist = '0;
        m_correct = 0;
        m_total = 0;
        gen_hist = 7'($random(seed));
        if (gen_hist == '0) begin
            gen_hist = 7'h01;
        end

        // name, kind, ext, cal, navg, ndiv, thresh, mode, cycles, flip, total, correct
        add_test("ext_offset", K_RAND, 1'b1, 1'b0, 0, 0, 0, CHK_RESET, 24, -1, -1, -1);
        add_test("thresh_pos", K_RAND, 1'b1, 1'b0, 0, 0, 40, CHK_RESET, 24, -1, -1, -1);
        add_test("thresh_neg", K_RAND, 1'b1, 1'b0, 0, 0, -60, CHK_RESET, 24, -1, -1, -1);
        add_test("pfd_cal", K_CONST, 1'b1, 1'b1, 3, 2, 0, CHK_RESET, 32, -1, -1, -1);
        add_test("pfd_apply", K_CONST, 1'b0, 1'b0, 3, 2, 0, CHK_RESET, 4, -1, -1, -1);
        add_test("prbs_flush", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_RESET, 2, -1, -1, -1);
        add_test("prbs_align", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_ALIGN, 3, -1, -1, -1);
        add_test("prbs_run", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_RUN, 40, -1, 160, 160);
        add_test("prbs_freeze", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_FREEZE, 3, -1, 160, 160);
        add_test("prbs_clear", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_RESET, 2, -1, 0, 0);
        add_test("err_align", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_ALIGN, 3, -1, -1, -1);
        add_test("err_run", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_RUN, 30, 10, 120, 117);
        add_test("err_freeze", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_FREEZE, 3, -1, 120, 117);
        add_test("err_clear", K_PRBS, 1'b1, 1'b0, 0, 0, 0, CHK_RESET, 2, -1, 0, 0);

        cycle_limit = 4 + Nmargin;
        foreach (tests[i]) begin
            cycle_limit += tests[i].cycles;
        end

        repeat (4) @(posedge clk_adc);
        #2;
        for (int k = 0; k < Nti; k++) begin
            check_val($sformatf("dout_o[%0d]", k), 32'(dout[k]), 0);
            check_val($sformatf("pfd_offset_o[%0d]", k), 32'(pfd_offset[k]), 0);
        end
        check_val("rx_bits_o", 32'(rx_bits), 0);
        check_val("correct_bits_o", correct_bits, 0);
        check_val("total_bits_o", total_bits, 0);
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test 0 reset_state: %s", (errors == 0) ? "ok" : "mismatch");
        reset = 1'b0;

        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests.size() + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/dcore_pkg.sv
logic/dcore_cfg_intf.sv
logic/avg_strobe_div.sv
logic/adc_unfolding.sv
logic/slice_comparator.sv
logic/prbs_checker.sv
logic/rx_dcore_top.sv
tb/tb_rx_dcore.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rx digital core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rx_dcore --Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_rx_dcore" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
